// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_eth_mac_mii_fifo
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) hw/eth_macros.svh

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/eth_crc32.sv
// Nibble-wide reflected CRC-32 accumulator with clear and enable
`timescale 1ns/1ps
`default_nettype none

module eth_crc32 (
    input  wire                   logic_clk,
    input  wire                   logic_rst_n,
    input  wire                   clear,
    input  wire                   enable,
    input  wire eth_pkg::nibble_t nibble,
    output eth_pkg::crc_t         crc
);

    // Bit-reversed form of 0x04C11DB7
    localparam eth_pkg::crc_t POLY = 32'hedb88320;

    // Fold one nibble in, LSB first as on the wire
    function automatic eth_pkg::crc_t crc_step(eth_pkg::crc_t c, eth_pkg::nibble_t d);
        eth_pkg::crc_t r;
        r = c;
        for (int i = 0; i < 4; i++) begin
            r = (r[0] ^ d[i]) ? ((r >> 1) ^ POLY) : (r >> 1);
        end
        return r;
    endfunction

    always_ff @(posedge logic_clk or negedge logic_rst_n) begin
        if (!logic_rst_n) begin
            crc <= '1;
        end else if (clear) begin
            crc <= '1;
        end else if (enable) begin
            crc <= crc_step(crc, nibble);
        end
    end

endmodule

`default_nettype wire

// File: hw/eth_frame_fifo.sv
// Byte frame FIFO that commits good frames and rolls back bad or overflowing ones
`timescale 1ns/1ps
`default_nettype none

module eth_frame_fifo #(
    parameter int DEPTH_LOG2 = 11
) (
    input  wire                 logic_clk,
    input  wire                 logic_rst_n,
    input  wire                 drop,
    input  wire eth_pkg::data_t in_data,
    input  wire                 in_valid,
    output logic                in_ready,
    input  wire                 in_last,
    input  wire                 in_bad,
    output eth_pkg::data_t      out_data,
    output logic                out_valid,
    input  wire                 out_ready,
    output logic                out_last,
    output logic                overflow,
    output logic                bad_frame,
    output logic                good_frame
);

    typedef logic [DEPTH_LOG2:0] ptr_t;

    // Last flag stored above each byte
    logic [8:0] mem [2**DEPTH_LOG2];

    ptr_t wr_ptr;
    ptr_t wr_ptr_commit;
    ptr_t rd_ptr;
    logic in_frame;
    logic drop_frame;
    logic ovf_frame;

    logic full;
    logic empty;
    logic in_fire;
    logic discard;
    logic wr_en;
    logic rd_load;

    assign full = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]) &&
                  (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);
    // Reader only sees bytes of committed frames
    assign empty = (rd_ptr == wr_ptr_commit);
    assign in_fire = in_valid && in_ready;
    // Drop is sampled on the first byte of a frame
    assign discard = drop_frame || (!in_frame && drop);
    assign wr_en = in_fire && !discard && !ovf_frame && !full;
    assign rd_load = !empty && (!out_valid || out_ready);

    always_ff @(posedge logic_clk or negedge logic_rst_n) begin
        if (!logic_rst_n) begin
            in_ready <= 1'b0;
            wr_ptr <= '0;
            wr_ptr_commit <= '0;
            rd_ptr <= '0;
            in_frame <= 1'b0;
            drop_frame <= 1'b0;
            ovf_frame <= 1'b0;
            out_valid <= 1'b0;
            overflow <= 1'b0;
            bad_frame <= 1'b0;
            good_frame <= 1'b0;
        end else begin
            in_ready <= 1'b1;
            overflow <= 1'b0;
            bad_frame <= 1'b0;
            good_frame <= 1'b0;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (in_fire) begin
                in_frame <= !in_last;
                drop_frame <= discard && !in_last;
                // Once full, the rest of the frame is ignored
                ovf_frame <= !discard && (ovf_frame || full) && !in_last;
                if (in_last) begin
                    if (discard) begin
                        wr_ptr <= wr_ptr_commit;
                    end else if (ovf_frame || full) begin
                        wr_ptr <= wr_ptr_commit;
                        overflow <= 1'b1;
                    end else if (in_bad) begin
                        wr_ptr <= wr_ptr_commit;
                        bad_frame <= 1'b1;
                    end else begin
                        wr_ptr_commit <= wr_ptr + 1'b1;
                        good_frame <= 1'b1;
                    end
                end
            end
            if (rd_load) begin
                out_valid <= 1'b1;
                rd_ptr <= rd_ptr + 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= {in_last, in_data};
        end
        if (rd_load) begin
            {out_last, out_data} <= mem[rd_ptr[DEPTH_LOG2-1:0]];
        end
    end

endmodule

`default_nettype wire

// File: hw/eth_mac_mii_fifo.sv
// Ethernet MAC top level with MII pins and a frame FIFO on each side
`timescale 1ns/1ps
`default_nettype none
`include "eth_macros.svh"

module eth_mac_mii_fifo (
    input  wire                   logic_clk,
    input  wire                   logic_rst_n,
    input  wire                   logic_enable,
    input  wire eth_pkg::data_t   tx_axis_tdata,
    input  wire                   tx_axis_tvalid,
    output wire                   tx_axis_tready,
    input  wire                   tx_axis_tlast,
    input  wire                   tx_axis_tuser,
    output wire eth_pkg::data_t   rx_axis_tdata,
    output wire                   rx_axis_tvalid,
    input  wire                   rx_axis_tready,
    output wire                   rx_axis_tlast,
    input  wire eth_pkg::nibble_t mii_rxd,
    input  wire                   mii_rx_dv,
    input  wire                   mii_rx_er,
    output wire eth_pkg::nibble_t mii_txd,
    output wire                   mii_tx_en,
    output wire                   mii_tx_er,
    output wire                   tx_fifo_overflow,
    output wire                   tx_fifo_bad_frame,
    output wire                   tx_fifo_good_frame,
    output wire                   rx_error_bad_frame,
    output wire                   rx_error_bad_fcs,
    output wire                   rx_fifo_overflow,
    output wire                   rx_fifo_bad_frame,
    output wire                   rx_fifo_good_frame,
    input  wire [7:0]             ifg_delay
);

    // TX FIFO to MAC
    eth_pkg::data_t tx_fifo_data;
    logic           tx_fifo_valid;
    logic           tx_fifo_ready;
    logic           tx_fifo_last;

    // RX MAC to FIFO, strobed without ready
    eth_pkg::data_t rx_mac_data;
    logic           rx_mac_valid;
    logic           rx_mac_last;
    logic           rx_mac_bad;

    eth_frame_fifo #(
        .DEPTH_LOG2(`ETH_TX_FIFO_DEPTH_LOG2)
    ) tx_fifo (
        .logic_clk  (logic_clk),
        .logic_rst_n(logic_rst_n),
        .drop       (~logic_enable),
        .in_data    (tx_axis_tdata),
        .in_valid   (tx_axis_tvalid),
        .in_ready   (tx_axis_tready),
        .in_last    (tx_axis_tlast),
        .in_bad     (tx_axis_tuser),
        .out_data   (tx_fifo_data),
        .out_valid  (tx_fifo_valid),
        .out_ready  (tx_fifo_ready),
        .out_last   (tx_fifo_last),
        .overflow   (tx_fifo_overflow),
        .bad_frame  (tx_fifo_bad_frame),
        .good_frame (tx_fifo_good_frame)
    );

    eth_mii_tx i_tx (
        .logic_clk  (logic_clk),
        .logic_rst_n(logic_rst_n),
        .in_data    (tx_fifo_data),
        .in_valid   (tx_fifo_valid),
        .in_ready   (tx_fifo_ready),
        .in_last    (tx_fifo_last),
        .ifg_delay  (ifg_delay),
        .mii_txd    (mii_txd),
        .mii_tx_en  (mii_tx_en),
        .mii_tx_er  (mii_tx_er)
    );

    eth_mii_rx i_rx (
        .logic_clk      (logic_clk),
        .logic_rst_n    (logic_rst_n),
        .mii_rxd        (mii_rxd),
        .mii_rx_dv      (mii_rx_dv),
        .mii_rx_er      (mii_rx_er),
        .out_data       (rx_mac_data),
        .out_valid      (rx_mac_valid),
        .out_last       (rx_mac_last),
        .out_bad        (rx_mac_bad),
        .error_bad_frame(rx_error_bad_frame),
        .error_bad_fcs  (rx_error_bad_fcs)
    );

    // Write side never stalls, so its ready stays open
    eth_frame_fifo #(
        .DEPTH_LOG2(`ETH_RX_FIFO_DEPTH_LOG2)
    ) rx_fifo (
        .logic_clk  (logic_clk),
        .logic_rst_n(logic_rst_n),
        .drop       (~logic_enable),
        .in_data    (rx_mac_data),
        .in_valid   (rx_mac_valid),
        .in_ready   (),
        .in_last    (rx_mac_last),
        .in_bad     (rx_mac_bad),
        .out_data   (rx_axis_tdata),
        .out_valid  (rx_axis_tvalid),
        .out_ready  (rx_axis_tready),
        .out_last   (rx_axis_tlast),
        .overflow   (rx_fifo_overflow),
        .bad_frame  (rx_fifo_bad_frame),
        .good_frame (rx_fifo_good_frame)
    );

endmodule

`default_nettype wire

// File: hw/eth_macros.svh
// Frame constants and default FIFO depths for the Ethernet MAC
`ifndef ETH_MACROS_SVH
`define ETH_MACROS_SVH

// Minimum frame length including the FCS
`define ETH_MIN_FRAME_LEN 64

// Preamble nibbles of value 5 sent before the SFD
`define ETH_PREAMBLE_NIBBLES 15

// Start of frame delimiter nibble
`define ETH_SFD_NIBBLE 4'hd

// CRC register after a good frame and its FCS
`define ETH_CRC_RESIDUE 32'hdebb20e3

// FIFO depths as powers of two
`define ETH_TX_FIFO_DEPTH_LOG2 11
`define ETH_RX_FIFO_DEPTH_LOG2 11

`endif

// File: hw/eth_mii_rx.sv
// MII receive stage with SFD search, byte assembly, FCS check and FCS stripping
`timescale 1ns/1ps
`default_nettype none
`include "eth_macros.svh"

module eth_mii_rx (
    input  wire                   logic_clk,
    input  wire                   logic_rst_n,
    input  wire eth_pkg::nibble_t mii_rxd,
    input  wire                   mii_rx_dv,
    input  wire                   mii_rx_er,
    output eth_pkg::data_t        out_data,
    output logic                  out_valid,
    output logic                  out_last,
    output logic                  out_bad,
    output logic                  error_bad_frame,
    output logic                  error_bad_fcs
);

    typedef enum logic [1:0] {IDLE, PREAMBLE, DATA} state_t;

    state_t           state;
    logic             nib_hi;
    logic [2:0]       byte_cnt;
    logic             er_seen;
    eth_pkg::nibble_t lo_nib;
    eth_pkg::crc_t    crc;

    // Four FCS candidates plus the pending payload byte
    eth_pkg::data_t hold [5];

    logic byte_done;
    logic frame_end;
    logic framing_err;
    logic fcs_err;

    assign byte_done = (state == DATA) && mii_rx_dv && nib_hi;
    assign frame_end = (state == DATA) && !mii_rx_dv;
    // Odd nibble count or a short frame counts as framing
    assign framing_err = er_seen || nib_hi || (byte_cnt < 3'd5);
    assign fcs_err = !framing_err && (crc != `ETH_CRC_RESIDUE);

    eth_crc32 i_crc (
        .logic_clk  (logic_clk),
        .logic_rst_n(logic_rst_n),
        .clear      (state != DATA),
        .enable     ((state == DATA) && mii_rx_dv),
        .nibble     (mii_rxd),
        .crc        (crc)
    );

    always_ff @(posedge logic_clk or negedge logic_rst_n) begin
        if (!logic_rst_n) begin
            state <= IDLE;
            nib_hi <= 1'b0;
            byte_cnt <= '0;
            er_seen <= 1'b0;
            out_valid <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs <= 1'b0;
            case (state)
                IDLE: begin
                    nib_hi <= 1'b0;
                    byte_cnt <= '0;
                    er_seen <= mii_rx_dv && mii_rx_er;
                    if (mii_rx_dv) begin
                        state <= (mii_rxd == `ETH_SFD_NIBBLE) ? DATA : PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    er_seen <= er_seen || mii_rx_er;
                    if (!mii_rx_dv) begin
                        state <= IDLE;
                    end else if (mii_rxd == `ETH_SFD_NIBBLE) begin
                        state <= DATA;
                    end
                end
                DATA: begin
                    if (mii_rx_dv) begin
                        nib_hi <= !nib_hi;
                        er_seen <= er_seen || mii_rx_er;
                        if (nib_hi && (byte_cnt == 3'd5)) begin
                            out_valid <= 1'b1;
                        end else if (nib_hi) begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end else begin
                        // Short frames never reached the FIFO
                        out_valid <= (byte_cnt == 3'd5);
                        error_bad_frame <= framing_err;
                        error_bad_fcs <= fcs_err;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge logic_clk) begin
        if ((state == DATA) && mii_rx_dv && !nib_hi) begin
            lo_nib <= mii_rxd;
        end
        if (byte_done) begin
            hold[0] <= {mii_rxd, lo_nib};
            for (int i = 1; i < 5; i++) begin
                hold[i] <= hold[i-1];
            end
            out_data <= hold[4];
            out_last <= 1'b0;
            out_bad <= 1'b0;
        end else if (frame_end) begin
            out_data <= hold[4];
            out_last <= 1'b1;
            out_bad <= framing_err || fcs_err;
        end
    end

endmodule

`default_nettype wire

// File: hw/eth_mii_tx.sv
// MII transmit stage with preamble, nibble serialization, padding, FCS and gap
`timescale 1ns/1ps
`default_nettype none
`include "eth_macros.svh"

module eth_mii_tx (
    input  wire                 logic_clk,
    input  wire                 logic_rst_n,
    input  wire eth_pkg::data_t in_data,
    input  wire                 in_valid,
    output logic                in_ready,
    input  wire                 in_last,
    input  wire [7:0]           ifg_delay,
    output eth_pkg::nibble_t    mii_txd,
    output logic                mii_tx_en,
    output logic                mii_tx_er
);

    // Bytes before the FCS in a minimum frame
    localparam int PAD_BYTES = `ETH_MIN_FRAME_LEN - 4;

    typedef enum logic [2:0] {IDLE, PREAMBLE, DATA, PAD, FCS, GAP} state_t;

    state_t           state;
    logic [8:0]       cnt;
    logic [6:0]       byte_cnt;
    logic             nib_hi;
    eth_pkg::crc_t    crc;
    eth_pkg::nibble_t data_nibble;
    logic [6:0]       byte_cnt_inc;
    logic [8:0]       gap_len;

    // Byte is taken as its high nibble goes out
    assign in_ready = (state == DATA) && nib_hi;
    assign mii_tx_er = 1'b0;
    // Pad nibbles are zero
    assign data_nibble = (state == DATA) ? (nib_hi ? in_data[7:4] : in_data[3:0]) : 4'h0;
    assign byte_cnt_inc = (byte_cnt == PAD_BYTES) ? byte_cnt : byte_cnt + 1'b1;
    assign gap_len = (ifg_delay == 8'd0) ? 9'd2 : {ifg_delay, 1'b0};

    eth_crc32 i_crc (
        .logic_clk  (logic_clk),
        .logic_rst_n(logic_rst_n),
        .clear      (state == IDLE),
        .enable     ((state == DATA) || (state == PAD)),
        .nibble     (data_nibble),
        .crc        (crc)
    );

    always_ff @(posedge logic_clk or negedge logic_rst_n) begin
        if (!logic_rst_n) begin
            state <= IDLE;
            cnt <= '0;
            byte_cnt <= '0;
            nib_hi <= 1'b0;
            mii_txd <= 4'h0;
            mii_tx_en <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    mii_txd <= 4'h0;
                    mii_tx_en <= 1'b0;
                    byte_cnt <= '0;
                    nib_hi <= 1'b0;
                    if (in_valid) begin
                        mii_txd <= 4'h5;
                        mii_tx_en <= 1'b1;
                        cnt <= 9'd1;
                        state <= PREAMBLE;
                    end
                end
                PREAMBLE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == `ETH_PREAMBLE_NIBBLES) begin
                        mii_txd <= `ETH_SFD_NIBBLE;
                        state <= DATA;
                    end else begin
                        mii_txd <= 4'h5;
                    end
                end
                DATA: begin
                    mii_txd <= data_nibble;
                    nib_hi <= !nib_hi;
                    if (nib_hi) begin
                        byte_cnt <= byte_cnt_inc;
                        if (in_last) begin
                            cnt <= '0;
                            state <= (byte_cnt_inc == PAD_BYTES) ? FCS : PAD;
                        end
                    end
                end
                PAD: begin
                    mii_txd <= data_nibble;
                    nib_hi <= !nib_hi;
                    if (nib_hi) begin
                        byte_cnt <= byte_cnt_inc;
                        if (byte_cnt_inc == PAD_BYTES) begin
                            cnt <= '0;
                            state <= FCS;
                        end
                    end
                end
                FCS: begin
                    // Complemented CRC, low nibble first
                    mii_txd <= ~crc[4*cnt[2:0] +: 4];
                    cnt <= cnt + 1'b1;
                    if (cnt == 9'd7) begin
                        cnt <= '0;
                        state <= GAP;
                    end
                end
                GAP: begin
                    mii_txd <= 4'h0;
                    mii_tx_en <= 1'b0;
                    cnt <= cnt + 1'b1;
                    if (cnt == gap_len - 9'd1) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/eth_pkg.sv
// Package with the stream byte, MII nibble and CRC register types
`default_nettype none

package eth_pkg;

    // One byte of the frame stream
    typedef logic [7:0] data_t;

    // One MII nibble
    typedef logic [3:0] nibble_t;

    // Reflected CRC-32 register
    typedef logic [31:0] crc_t;

endpackage

`default_nettype wire

// File: tb.f
+incdir+hw
hw/eth_pkg.sv
hw/eth_crc32.sv
hw/eth_frame_fifo.sv
hw/eth_mii_tx.sv
hw/eth_mii_rx.sv
hw/eth_mac_mii_fifo.sv
verif/tb_eth_mac_mii_fifo.sv

// File: verif/tb_eth_mac_mii_fifo.sv
// Table-driven loopback testbench for the Ethernet MAC with MII pins and frame FIFOs
`timescale 1ns/1ps
`default_nettype none
`include "eth_macros.svh"

module tb_eth_mac_mii_fifo;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    // Bytes before the FCS in a minimum frame
    localparam int MIN_PAYLOAD = `ETH_MIN_FRAME_LEN - 4;
    // Wire nibble hit by a corruption, counted from the first preamble nibble
    localparam int HIT_NIBBLE = 40;
    localparam int HIT_NONE = 0;
    localparam int HIT_FLIP = 1;
    localparam int HIT_RX_ER = 2;

    logic                  logic_clk = 1'b0;
    logic                  logic_rst_n;
    logic                  logic_enable;
    eth_pkg::data_t        tx_axis_tdata;
    logic                  tx_axis_tvalid;
    wire                   tx_axis_tready;
    logic                  tx_axis_tlast;
    logic                  tx_axis_tuser;
    wire eth_pkg::data_t   rx_axis_tdata;
    wire                   rx_axis_tvalid;
    logic                  rx_axis_tready = 1'b0;
    wire                   rx_axis_tlast;
    eth_pkg::nibble_t      mii_rxd = 4'h0;
    logic                  mii_rx_dv = 1'b0;
    logic                  mii_rx_er = 1'b0;
    wire eth_pkg::nibble_t mii_txd;
    wire                   mii_tx_en;
    wire                   mii_tx_er;
    wire                   tx_fifo_overflow;
    wire                   tx_fifo_bad_frame;
    wire                   tx_fifo_good_frame;
    wire                   rx_error_bad_frame;
    wire                   rx_error_bad_fcs;
    wire                   rx_fifo_overflow;
    wire                   rx_fifo_bad_frame;
    wire                   rx_fifo_good_frame;
    logic [7:0]            ifg_delay;

    // Test table with one entry per row
    string       row_name[$];
    int          row_len[$];
    int          row_frames[$];
    bit          row_tuser[$];
    bit          row_enable[$];
    int          row_hit[$];
    int          row_ifg[$];
    bit          row_rx[$];
    // Pulse counts as nibbles from tx good down to fcs
    // Order is tx good, tx bad, tx ovf, rx good, rx bad, rx ovf, frame, fcs
    logic [31:0] row_pulses[$];

    eth_pkg::data_t exp_data[$];
    bit             exp_last[$];
    int             rx_seen;
    int             pulse_count[8];
    int             pulse_base[8];
    string          cur_name = "reset";
    int             cur_ifg;
    int             cur_hit;
    int             wire_nibble;
    int             idle_run;
    logic           hit_now;

    eth_mac_mii_fifo i_eth_mac_mii_fifo (
        .logic_clk         (logic_clk),
        .logic_rst_n       (logic_rst_n),
        .logic_enable      (logic_enable),
        .tx_axis_tdata     (tx_axis_tdata),
        .tx_axis_tvalid    (tx_axis_tvalid),
        .tx_axis_tready    (tx_axis_tready),
        .tx_axis_tlast     (tx_axis_tlast),
        .tx_axis_tuser     (tx_axis_tuser),
        .rx_axis_tdata     (rx_axis_tdata),
        .rx_axis_tvalid    (rx_axis_tvalid),
        .rx_axis_tready    (rx_axis_tready),
        .rx_axis_tlast     (rx_axis_tlast),
        .mii_rxd           (mii_rxd),
        .mii_rx_dv         (mii_rx_dv),
        .mii_rx_er         (mii_rx_er),
        .mii_txd           (mii_txd),
        .mii_tx_en         (mii_tx_en),
        .mii_tx_er         (mii_tx_er),
        .tx_fifo_overflow  (tx_fifo_overflow),
        .tx_fifo_bad_frame (tx_fifo_bad_frame),
        .tx_fifo_good_frame(tx_fifo_good_frame),
        .rx_error_bad_frame(rx_error_bad_frame),
        .rx_error_bad_fcs  (rx_error_bad_fcs),
        .rx_fifo_overflow  (rx_fifo_overflow),
        .rx_fifo_bad_frame (rx_fifo_bad_frame),
        .rx_fifo_good_frame(rx_fifo_good_frame),
        .ifg_delay         (ifg_delay)
    );

    always #(CLK_PERIOD / 2) logic_clk = ~logic_clk;

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    function automatic int padded_len(input int len);
        return (len < MIN_PAYLOAD) ? MIN_PAYLOAD : len;
    endfunction

    // Twice ifg_delay, never below two cycles
    function automatic int gap_cycles(input int ifg);
        return (2 * ifg < 2) ? 2 : 2 * ifg;
    endfunction

    // Preamble and SFD, data nibbles, FCS and gap on the wire
    function automatic int frame_cycles(input int len, input int ifg);
        return 16 + 2 * padded_len(len) + 8 + gap_cycles(ifg);
    endfunction

    function automatic logic [31:0] pulses_since_start();
        logic [31:0] v;
        for (int k = 0; k < 8; k++) begin
            v[4*k +: 4] = 4'(pulse_count[k] - pulse_base[k]);
        end
        return v;
    endfunction

    function automatic bit pulses_reached(input logic [31:0] want);
        logic [31:0] got;
        got = pulses_since_start();
        for (int k = 0; k < 8; k++) begin
            if (got[4*k +: 4] < want[4*k +: 4]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Loopback through a register with one nibble optionally hit
    assign hit_now = mii_tx_en && (wire_nibble == HIT_NIBBLE);

    always @(posedge logic_clk) begin
        #1;
        mii_rxd <= mii_txd ^ {3'b000, hit_now && (cur_hit == HIT_FLIP)};
        mii_rx_dv <= mii_tx_en;
        mii_rx_er <= hit_now && (cur_hit == HIT_RX_ER);
        wire_nibble <= mii_tx_en ? wire_nibble + 1 : 0;
    end

    always @(posedge logic_clk) begin
        #1;
        rx_axis_tready <= ($urandom % 4) != 0;
    end

    // RX stream against the reference bytes
    always @(negedge logic_clk) begin
        if (logic_rst_n && rx_axis_tvalid && rx_axis_tready) begin
            assert (rx_seen < exp_data.size()) else begin
                $display("Unexpected RX byte %02h during row %s", rx_axis_tdata, cur_name);
                abort_run();
            end
            assert (rx_axis_tdata == exp_data[rx_seen]) else begin
                $display("MISMATCH %s data at byte %0d: expected %02h, actual %02h",
                         cur_name, rx_seen, exp_data[rx_seen], rx_axis_tdata);
                abort_run();
            end
            assert (rx_axis_tlast == exp_last[rx_seen]) else begin
                $display("MISMATCH %s last at byte %0d: expected %0d, actual %0d",
                         cur_name, rx_seen, exp_last[rx_seen], rx_axis_tlast);
                abort_run();
            end
            rx_seen = rx_seen + 1;
        end
    end

    // Status pulses, transmit gap and tx_er
    always @(negedge logic_clk) begin
        if (logic_rst_n) begin
            pulse_count[7] = pulse_count[7] + (tx_fifo_good_frame ? 1 : 0);
            pulse_count[6] = pulse_count[6] + (tx_fifo_bad_frame ? 1 : 0);
            pulse_count[5] = pulse_count[5] + (tx_fifo_overflow ? 1 : 0);
            pulse_count[4] = pulse_count[4] + (rx_fifo_good_frame ? 1 : 0);
            pulse_count[3] = pulse_count[3] + (rx_fifo_bad_frame ? 1 : 0);
            pulse_count[2] = pulse_count[2] + (rx_fifo_overflow ? 1 : 0);
            pulse_count[1] = pulse_count[1] + (rx_error_bad_frame ? 1 : 0);
            pulse_count[0] = pulse_count[0] + (rx_error_bad_fcs ? 1 : 0);
            assert (!mii_tx_er) else begin
                $display("mii_tx_er went high during row %s", cur_name);
                abort_run();
            end
            if (mii_tx_en) begin
                if (idle_run > 0) begin
                    assert (idle_run >= gap_cycles(cur_ifg)) else begin
                        $display("MISMATCH %s gap: expected at least %0d, actual %0d",
                                 cur_name, gap_cycles(cur_ifg), idle_run);
                        abort_run();
                    end
                end
                idle_run = 0;
            end else begin
                idle_run = idle_run + 1;
            end
        end
    end

    task automatic add_row(input string name, input int len, input int frames,
                           input bit tuser, input bit enable, input int hit,
                           input int ifg, input bit rx, input logic [31:0] pulses);
        row_name.push_back(name);
        row_len.push_back(len);
        row_frames.push_back(frames);
        row_tuser.push_back(tuser);
        row_enable.push_back(enable);
        row_hit.push_back(hit);
        row_ifg.push_back(ifg);
        row_rx.push_back(rx);
        row_pulses.push_back(pulses);
    endtask

    task automatic build_table();
        //      name               len frm tuser en  hit        ifg rx  pulses
        add_row("good_100",        100, 1, 1'b0, 1'b1, HIT_NONE,  6, 1'b1, 32'h10010000);
        add_row("pad_20",           20, 1, 1'b0, 1'b1, HIT_NONE,  6, 1'b1, 32'h10010000);
        add_row("tuser_bad",        50, 1, 1'b1, 1'b1, HIT_NONE,  6, 1'b0, 32'h01000000);
        add_row("fcs_flip",         80, 1, 1'b0, 1'b1, HIT_FLIP,  6, 1'b0, 32'h10001001);
        add_row("good_after_flip",  64, 1, 1'b0, 1'b1, HIT_NONE,  6, 1'b1, 32'h10010000);
        add_row("rx_er",            70, 1, 1'b0, 1'b1, HIT_RX_ER, 6, 1'b0, 32'h10001010);
        add_row("good_after_er",    46, 1, 1'b0, 1'b1, HIT_NONE,  6, 1'b1, 32'h10010000);
        add_row("disabled",         40, 1, 1'b0, 1'b0, HIT_NONE,  6, 1'b0, 32'h00000000);
        add_row("enabled_again",    40, 1, 1'b0, 1'b1, HIT_NONE,  6, 1'b1, 32'h10010000);
        add_row("burst_ifg12",      75, 4, 1'b0, 1'b1, HIT_NONE, 12, 1'b1, 32'h40040000);
        add_row("burst_ifg0",       60, 3, 1'b0, 1'b1, HIT_NONE,  0, 1'b1, 32'h30030000);
    endtask

    task automatic send_frame(input eth_pkg::data_t bytes[$], input bit bad);
        for (int i = 0; i < bytes.size(); i++) begin
            tx_axis_tdata = bytes[i];
            tx_axis_tvalid = 1'b1;
            tx_axis_tlast = (i == bytes.size() - 1);
            tx_axis_tuser = bad;
            // Byte moves on the next edge where ready is seen high
            @(negedge logic_clk);
            while (!tx_axis_tready) begin
                @(negedge logic_clk);
            end
            @(posedge logic_clk);
            #1;
        end
        tx_axis_tvalid = 1'b0;
        tx_axis_tlast = 1'b0;
        tx_axis_tuser = 1'b0;
    endtask

    task automatic run_row(input int r);
        eth_pkg::data_t payload[$];
        logic [31:0]    got;
        int             len;
        cur_name = row_name[r];
        cur_ifg = row_ifg[r];
        cur_hit = row_hit[r];
        ifg_delay = 8'(row_ifg[r]);
        logic_enable = row_enable[r];
        pulse_base = pulse_count;
        len = row_len[r];
        for (int f = 0; f < row_frames[r]; f++) begin
            payload.delete();
            for (int i = 0; i < len; i++) begin
                payload.push_back(eth_pkg::data_t'($urandom));
            end
            // Short frames come back zero padded to the minimum length
            if (row_rx[r]) begin
                for (int i = 0; i < padded_len(len); i++) begin
                    exp_data.push_back((i < len) ? payload[i] : 8'h00);
                    exp_last.push_back(i == padded_len(len) - 1);
                end
            end
            send_frame(payload, row_tuser[r]);
        end
        while (!(pulses_reached(row_pulses[r]) && (rx_seen == exp_data.size()))) begin
            @(posedge logic_clk);
        end
        // One more frame time for late or extra output
        repeat (frame_cycles(len, row_ifg[r])) @(posedge logic_clk);
        #1;
        got = pulses_since_start();
        assert (got == row_pulses[r]) else begin
            $display("MISMATCH %s status pulses: expected %08h, actual %08h",
                     cur_name, row_pulses[r], got);
            abort_run();
        end
    endtask

    initial begin
        int budget;
        logic_rst_n = 1'b0;
        logic_enable = 1'b1;
        tx_axis_tdata = 8'h00;
        tx_axis_tvalid = 1'b0;
        tx_axis_tlast = 1'b0;
        tx_axis_tuser = 1'b0;
        ifg_delay = 8'd0;
        void'($urandom(42));
        build_table();
        budget = RESET_CYCLES + 10;
        foreach (row_name[r]) begin
            budget = budget + 50 * row_frames[r] * frame_cycles(row_len[r], row_ifg[r]);
        end
        fork
            begin
                repeat (budget) @(posedge logic_clk);
                $display("Watchdog expired after %0d cycles in row %s, the DUT hung",
                         budget, cur_name);
                abort_run();
            end
        join_none
        repeat (RESET_CYCLES) @(posedge logic_clk);
        #1;
        logic_rst_n = 1'b1;
        @(posedge logic_clk);
        #1;
        foreach (row_name[r]) begin
            run_row(r);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire
